// File: rtl/lsu_pkg.sv
////////////////////////////////////////////////////////////////////////////
// lsu package: widths, access-size and extension codes, outstanding depth
// and the packed structs shared by the load/store unit blocks
////////////////////////////////////////////////////////////////////////////

package lsu_pkg;

  // plain vector types with a meaning
  typedef logic [31:0] word_t;      // data or address word
  typedef logic [3:0]  be_t;        // one enable per byte lane
  typedef logic [1:0]  byte_off_t;  // byte offset inside a word
  typedef logic [1:0]  mem_size_t;  // access size code
  typedef logic [1:0]  ext_mode_t;  // load extension code
  typedef logic [1:0]  cnt_t;       // outstanding transaction count

  ////////////////////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////////////////////

  localparam mem_size_t LSU_SIZE_WORD = 2'b00;
  localparam mem_size_t LSU_SIZE_HALF = 2'b01;
  localparam mem_size_t LSU_SIZE_BYTE = 2'b10;  // 11 decodes as byte too

  localparam ext_mode_t LSU_EXT_ZERO = 2'b00;
  localparam ext_mode_t LSU_EXT_SIGN = 2'b01;   // 11 decodes as sign too
  localparam ext_mode_t LSU_EXT_ONES = 2'b10;

  localparam int LSU_DEPTH = 2;  // max outstanding bus transactions

  ////////////////////////////////////////////////////////////////////////////
  // structs
  ////////////////////////////////////////////////////////////////////////////

  // access as presented by the EX stage
  typedef struct packed {
    logic      we;            // store when set
    mem_size_t size;
    ext_mode_t ext;
    byte_off_t reg_off;       // byte offset of the data inside the register
    logic      use_incr;      // address is op_a + op_b
    logic      second_phase;  // second half of a misaligned access
    word_t     op_a;
    word_t     op_b;
    word_t     wdata;
  } ex_req_t;

  // OBI address phase
  typedef struct packed {
    word_t addr;
    logic  we;
    be_t   be;
    word_t wdata;
  } obi_req_t;

  // control kept for the response phase
  typedef struct packed {
    logic      we;
    mem_size_t size;
    ext_mode_t ext;
    byte_off_t off;
  } wb_ctrl_t;

endpackage

// File: rtl/lsu_request.sv
////////////////////////////////////////////////////////////////////////////
// lsu request path: address generation, misalignment detection, byte
// enables and write data rotation, forming the OBI address phase
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_request (
  input  logic              ex_valid_i,
  input  lsu_pkg::ex_req_t  ex_req_i,
  input  lsu_pkg::cnt_t     cnt_i,
  output logic              data_req_o,
  output lsu_pkg::obi_req_t bus_req_o,
  output lsu_pkg::byte_off_t addr_off_o,
  output logic              data_misaligned_o
);

  import lsu_pkg::*;

  word_t     addr;       // full byte address of the access
  byte_off_t off;        // low address bits
  byte_off_t wdata_sh;   // rotation amount in bytes
  be_t       be;
  word_t     wdata_rot;

  // address from operands
  assign addr = ex_req_i.use_incr ? (ex_req_i.op_a + ex_req_i.op_b) : ex_req_i.op_a;
  assign off  = addr[1:0];

  ////////////////////////////////////////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (ex_req_i.size)
      LSU_SIZE_WORD: begin
        if (!ex_req_i.second_phase) begin
          be = be_t'(4'b1111 << off);  // upper lanes from the offset
        end else begin
          be = be_t'(4'b1111 >> (3'd4 - {1'b0, off}));  // spill lanes, 0 at offset 0
        end
      end
      LSU_SIZE_HALF: begin
        if (!ex_req_i.second_phase) begin
          be = be_t'(4'b0011 << off);  // offset 3 keeps only lane 3
        end else begin
          be = 4'b0001;              // upper byte lands in lane 0
        end
      end
      default: be = be_t'(4'b0001 << off);  // byte, both codes
    endcase
  end

  // misaligned when a word is off a word boundary, or a half crosses it
  always_comb begin
    data_misaligned_o = 1'b0;
    if (ex_valid_i && !ex_req_i.second_phase) begin
      case (ex_req_i.size)
        LSU_SIZE_WORD: data_misaligned_o = (off != 2'b00);
        LSU_SIZE_HALF: data_misaligned_o = (off == 2'b11);
        default:       data_misaligned_o = 1'b0;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // write data rotation
  ////////////////////////////////////////////////////////////////////////////

  assign wdata_sh = off - ex_req_i.reg_off;  // wraps mod 4

  always_comb begin
    case (wdata_sh)
      2'b00:   wdata_rot = ex_req_i.wdata;
      2'b01:   wdata_rot = {ex_req_i.wdata[23:0], ex_req_i.wdata[31:24]};
      2'b10:   wdata_rot = {ex_req_i.wdata[15:0], ex_req_i.wdata[31:16]};
      default: wdata_rot = {ex_req_i.wdata[7:0],  ex_req_i.wdata[31:8]};
    endcase
  end

  // request only while below the outstanding limit
  assign data_req_o = ex_valid_i && (cnt_i < cnt_t'(LSU_DEPTH));

  // second phase goes to the next word, which EX already points at
  assign bus_req_o.addr  = ex_req_i.second_phase ? {addr[31:2], 2'b00} : addr;
  assign bus_req_o.we    = ex_req_i.we;
  assign bus_req_o.be    = be;
  assign bus_req_o.wdata = wdata_rot;

  assign addr_off_o = off;  // for load data alignment

endmodule

// File: rtl/lsu_txn_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// lsu transaction control: outstanding count, EX and WB readiness,
// busy flag and the strobe that moves an access from EX into WB
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_txn_ctrl (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          ex_valid_i,
  input  logic          data_req_i,
  input  logic          data_gnt_i,
  input  logic          data_rvalid_i,
  output lsu_pkg::cnt_t cnt_o,
  output logic          lsu_ready_ex_o,
  output logic          lsu_ready_wb_o,
  output logic          busy_o,
  output logic          upd_o
);

  import lsu_pkg::*;

  cnt_t cnt_q;
  cnt_t cnt_d;
  logic count_up;    // address phase accepted
  logic count_down;  // response returned
  logic accepted;

  assign accepted   = data_req_i && data_gnt_i;
  assign count_up   = accepted;
  assign count_down = data_rvalid_i;  // rvalid only follows an accepted request

  ////////////////////////////////////////////////////////////////////////////
  // outstanding counter
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + cnt_t'(1);
      2'b01:   cnt_d = cnt_q - cnt_t'(1);
      default: cnt_d = cnt_q;  // idle, or one in and one out
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  assign cnt_o = cnt_q;

  ////////////////////////////////////////////////////////////////////////////
  // readiness
  ////////////////////////////////////////////////////////////////////////////

  // WB is free when empty, or when its pending response arrives now
  assign lsu_ready_wb_o = (cnt_q == '0) ? 1'b1 : data_rvalid_i;

  // EX and WB advance together once WB holds an access
  always_comb begin
    if (!ex_valid_i) begin
      lsu_ready_ex_o = 1'b1;
    end else begin
      case (cnt_q)
        2'd0:    lsu_ready_ex_o = accepted;
        2'd1:    lsu_ready_ex_o = accepted && data_rvalid_i;
        default: lsu_ready_ex_o = data_rvalid_i;  // full, req is held off
      endcase
    end
  end

  assign upd_o  = lsu_ready_ex_o && ex_valid_i;  // load WB control
  assign busy_o = (cnt_q != '0) || data_req_i;   // in flight or about to be

endmodule

// File: rtl/lsu_rdata_align.sv
////////////////////////////////////////////////////////////////////////////
// lsu read data path: WB control register, two-beat assembly of
// misaligned loads, and zero, sign or ones extension
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_rdata_align (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               upd_i,
  input  lsu_pkg::ex_req_t   ex_req_i,
  input  lsu_pkg::byte_off_t addr_off_i,
  input  logic               misaligned_i,
  input  logic               rvalid_i,
  input  lsu_pkg::word_t     rdata_i,
  output lsu_pkg::word_t     ex_rdata_o
);

  import lsu_pkg::*;

  wb_ctrl_t    wb_q;       // control of the access awaiting its response
  word_t       rdata_q;    // first beat, or last finished load value
  word_t       rdata_w;    // word, assembled across beats if needed
  logic [15:0] half_sel;
  logic [7:0]  byte_sel;
  word_t       rdata_ext;

  // fill bit for the upper part of a narrow load
  function automatic logic ext_fill(input ext_mode_t mode, input logic msb);
    case (mode)
      LSU_EXT_ZERO: return 1'b0;
      LSU_EXT_ONES: return 1'b1;
      default:      return msb;  // 01 and 11
    endcase
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_q <= '0;
    end else if (upd_i) begin  // access moves on to wait for rvalid
      wb_q.we   <= ex_req_i.we;
      wb_q.size <= ex_req_i.size;
      wb_q.ext  <= ex_req_i.ext;
      wb_q.off  <= addr_off_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // lane selection
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (wb_q.off)
      2'b00: begin
        rdata_w  = rdata_i;
        half_sel = rdata_i[15:0];
        byte_sel = rdata_i[7:0];
      end
      2'b01: begin
        rdata_w  = {rdata_i[7:0], rdata_q[31:8]};
        half_sel = rdata_i[23:8];
        byte_sel = rdata_i[15:8];
      end
      2'b10: begin
        rdata_w  = {rdata_i[15:0], rdata_q[31:16]};
        half_sel = rdata_i[31:16];
        byte_sel = rdata_i[23:16];
      end
      default: begin
        rdata_w  = {rdata_i[23:0], rdata_q[31:24]};
        half_sel = {rdata_i[7:0], rdata_q[31:24]};  // straddles the boundary
        byte_sel = rdata_i[31:24];
      end
    endcase
  end

  // extend to the register width
  always_comb begin
    case (wb_q.size)
      LSU_SIZE_WORD: rdata_ext = rdata_w;
      LSU_SIZE_HALF: rdata_ext = {{16{ext_fill(wb_q.ext, half_sel[15])}}, half_sel};
      default:       rdata_ext = {{24{ext_fill(wb_q.ext, byte_sel[7])}}, byte_sel};
    endcase
  end

  // keep the raw first beat while a misaligned load is split, else the result
  always_ff @(posedge clk) begin
    if (rvalid_i && !wb_q.we) begin
      if (ex_req_i.second_phase || misaligned_i) begin
        rdata_q <= rdata_i;
      end else begin
        rdata_q <= rdata_ext;
      end
    end
  end

  assign ex_rdata_o = rvalid_i ? rdata_ext : rdata_q;

endmodule

// File: rtl/lsu_top.sv
////////////////////////////////////////////////////////////////////////////
// lsu top: data-memory load/store unit between the EX stage and an
// OBI data bus, up to two transactions in flight
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_top (
  input  logic              clk,
  input  logic              rst_n,
  // EX stage
  input  logic              ex_valid_i,
  input  lsu_pkg::ex_req_t  ex_req_i,
  output lsu_pkg::word_t    ex_rdata_o,
  output logic              data_misaligned_o,
  output logic              lsu_ready_ex_o,
  output logic              lsu_ready_wb_o,
  output logic              busy_o,
  // OBI data bus
  output logic              data_req_o,
  input  logic              data_gnt_i,
  input  logic              data_rvalid_i,
  output lsu_pkg::obi_req_t bus_req_o,
  input  lsu_pkg::word_t    data_rdata_i
);

  import lsu_pkg::*;

  cnt_t      cnt;       // outstanding count
  byte_off_t addr_off;  // access offset for load alignment
  logic      upd;       // EX to WB update

  lsu_request i_lsu_request (
    .ex_valid_i       (ex_valid_i),
    .ex_req_i         (ex_req_i),
    .cnt_i            (cnt),
    .data_req_o       (data_req_o),
    .bus_req_o        (bus_req_o),
    .addr_off_o       (addr_off),
    .data_misaligned_o(data_misaligned_o)
  );

  lsu_txn_ctrl i_lsu_txn_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .ex_valid_i    (ex_valid_i),
    .data_req_i    (data_req_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .cnt_o         (cnt),
    .lsu_ready_ex_o(lsu_ready_ex_o),
    .lsu_ready_wb_o(lsu_ready_wb_o),
    .busy_o        (busy_o),
    .upd_o         (upd)
  );

  lsu_rdata_align i_lsu_rdata_align (
    .clk         (clk),
    .rst_n       (rst_n),
    .upd_i       (upd),
    .ex_req_i    (ex_req_i),
    .addr_off_i  (addr_off),
    .misaligned_i(data_misaligned_o),
    .rvalid_i    (data_rvalid_i),
    .rdata_i     (data_rdata_i),
    .ex_rdata_o  (ex_rdata_o)
  );

endmodule

// File: verification/lsu_checker.sv
////////////////////////////////////////////////////////////////////////////
// lsu checker: bound assertions on outstanding count and OBI request
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_checker (
  input  logic              clk,
  input  logic              rst_n,
  input  lsu_pkg::cnt_t     cnt_i,      // outstanding count
  input  logic              rvalid_i,
  input  logic              req_i,
  input  logic              gnt_i,
  input  lsu_pkg::obi_req_t bus_req_i
);

  import lsu_pkg::*;

  // never more than the allowed number in flight
  count_limit: assert property (
    @(posedge clk) disable iff (!rst_n)
    cnt_i <= cnt_t'(LSU_DEPTH)
  ) else $error("outstanding count above depth");

  // a response needs an accepted request before it
  no_spurious_rvalid: assert property (
    @(posedge clk) disable iff (!rst_n)
    rvalid_i |-> (cnt_i != '0)
  ) else $error("rvalid with nothing outstanding");

  // address phase held until granted
  req_held: assert property (
    @(posedge clk) disable iff (!rst_n)
    (req_i && !gnt_i) |=> req_i
  ) else $error("req dropped before gnt");

  bus_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (req_i && !gnt_i) |=> $stable(bus_req_i)
  ) else $error("bus request changed while waiting for gnt");

endmodule

bind lsu_top lsu_checker i_lsu_checker (
  .clk      (clk),
  .rst_n    (rst_n),
  .cnt_i    (cnt),
  .rvalid_i (data_rvalid_i),
  .req_i    (data_req_o),
  .gnt_i    (data_gnt_i),
  .bus_req_i(bus_req_o)
);

// File: verification/lsu_tb.sv
////////////////////////////////////////////////////////////////////////////
// lsu testbench: EX-stage driver, OBI memory responder with random
// latency, load result monitor, all driven from a test data file
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_tb;

  import lsu_pkg::*;

  localparam int MAX_LINES  = 64;
  localparam int NUM_FIELDS = 18;  // columns per data line

  logic     clk;
  logic     rst_n;
  logic     ex_valid;
  ex_req_t  ex_req;
  word_t    ex_rdata;
  logic     misaligned;
  logic     ready_ex;
  logic     ready_wb;
  logic     busy;
  logic     data_req;
  logic     data_gnt;
  logic     data_rvalid;
  obi_req_t bus_req;
  word_t    data_rdata;

  word_t td [MAX_LINES][NUM_FIELDS];  // test data, one row per access
  int    num_lines;
  bit    loaded;
  bit    failed;
  bit    hold_gnt;                    // forces gnt low for back-pressure
  bit    depth_reached;               // two transactions were in flight at once
  int    seed;
  int    cycle;
  word_t beat_q[$];                   // memory beats for upcoming grants
  word_t rsp_data_q[$];               // granted, response pending
  int    rsp_time_q[$];
  word_t exp_rdata_q[$];              // expected per response beat
  bit    exp_check_q[$];

  lsu_top i_lsu_top (
    .clk              (clk),
    .rst_n            (rst_n),
    .ex_valid_i       (ex_valid),
    .ex_req_i         (ex_req),
    .ex_rdata_o       (ex_rdata),
    .data_misaligned_o(misaligned),
    .lsu_ready_ex_o   (ready_ex),
    .lsu_ready_wb_o   (ready_wb),
    .busy_o           (busy),
    .data_req_o       (data_req),
    .data_gnt_i       (data_gnt),
    .data_rvalid_i    (data_rvalid),
    .bus_req_o        (bus_req),
    .data_rdata_i     (data_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  ////////////////////////////////////////////////////////////////////////////
  // compare helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_on_failure();
    failed = 1'b1;
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t act, input word_t exp);
    if (act !== exp) begin
      $display("Error: %s = 0x%h, expected 0x%h", name, act, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_be(input string name, input be_t act, input be_t exp);
    if (act !== exp) begin
      $display("Error: %s = 0x%h, expected 0x%h", name, act, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("Error: %s = 0x%h, expected 0x%h", name, act, exp);
      stop_on_failure();
    end
  endtask

  // rows of hex columns, lines starting with # are skipped
  task automatic read_testdata();
    int    fd;
    int    n;
    string line;
    fd = $fopen("verification/lsu_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open the test data file");
      stop_on_failure();
    end else begin
      while (!$feof(fd) && num_lines < MAX_LINES) begin
        line = "";
        if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      td[num_lines][0], td[num_lines][1], td[num_lines][2],
                      td[num_lines][3], td[num_lines][4], td[num_lines][5],
                      td[num_lines][6], td[num_lines][7], td[num_lines][8],
                      td[num_lines][9], td[num_lines][10], td[num_lines][11],
                      td[num_lines][12], td[num_lines][13], td[num_lines][14],
                      td[num_lines][15], td[num_lines][16], td[num_lines][17]);
          if (n == NUM_FIELDS) num_lines++;
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // EX driver
  ////////////////////////////////////////////////////////////////////////////

  // present one phase, wait for acceptance, check the address phase
  task automatic drive_phase(input ex_req_t req, input word_t exp_addr, input be_t exp_be,
                             input word_t exp_wd, input logic exp_mis, input int stall);
    int waited;
    waited   = 0;
    ex_valid = 1'b1;
    ex_req   = req;
    do begin
      @(negedge clk);
      if (waited < stall) begin  // gnt held low here
        check_flag("data_req_o", data_req, 1'b1);
        check_flag("lsu_ready_ex_o", ready_ex, 1'b0);
        waited++;
        if (waited == stall) hold_gnt = 1'b0;
      end
    end while (ready_ex !== 1'b1);
    check_word("bus_req_o.addr", bus_req.addr, exp_addr);
    check_be("bus_req_o.be", bus_req.be, exp_be);
    check_flag("bus_req_o.we", bus_req.we, req.we);
    check_flag("data_misaligned_o", misaligned, exp_mis);
    if (req.we) check_word("bus_req_o.wdata", bus_req.wdata, exp_wd);
    @(posedge clk);
    #1;
  endtask

  task automatic run_access(input int i, input int stall);
    ex_req_t req;
    logic    mis;
    req.we           = td[i][0][0];
    req.size         = td[i][1][1:0];
    req.ext          = td[i][2][1:0];
    req.reg_off      = td[i][3][1:0];
    req.use_incr     = td[i][4][0];
    req.second_phase = 1'b0;
    req.op_a         = td[i][5];
    req.op_b         = td[i][6];
    req.wdata        = td[i][7];
    mis              = td[i][10][0];
    beat_q.push_back(td[i][8]);
    if (mis) begin
      beat_q.push_back(td[i][9]);
      exp_rdata_q.push_back('0);  // first beat of a split load is raw
      exp_check_q.push_back(1'b0);
    end
    exp_rdata_q.push_back(td[i][17]);
    exp_check_q.push_back(!req.we);
    drive_phase(req, td[i][11], td[i][12][3:0], td[i][13], mis, stall);
    if (mis) begin
      req.second_phase = 1'b1;
      req.op_a         = req.op_a + 32'd4;  // EX moves to the next word
      drive_phase(req, td[i][14], td[i][15][3:0], td[i][16], 1'b0, 0);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // memory responder and load monitor
  ////////////////////////////////////////////////////////////////////////////

  initial begin : responder
    int   gnt_wait;
    int   qsize;
    int   in_flight;
    logic rv_next;
    gnt_wait    = 0;
    data_gnt    = 1'b0;
    data_rvalid = 1'b0;
    data_rdata  = '0;
    forever begin
      @(negedge clk);
      in_flight = rsp_data_q.size() + int'(data_rvalid);  // granted, not yet retired
      if (rst_n && ex_valid && in_flight >= LSU_DEPTH) begin
        depth_reached = 1'b1;
        check_flag("data_req_o", data_req, 1'b0);  // full, no new request
        check_flag("lsu_ready_ex_o", ready_ex, data_rvalid);
      end
      if (data_req && data_gnt) begin
        if (beat_q.size() == 0) begin
          $display("bus accepted a request that the testbench never issued");
          stop_on_failure();
        end else begin
          rsp_data_q.push_back(beat_q.pop_front());
          rsp_time_q.push_back(cycle + 1 + int'($unsigned($random(seed)) % 3));
          gnt_wait = int'($unsigned($random(seed)) % 4);  // 0 to 3 cycles
        end
      end else if (data_req && gnt_wait > 0) begin
        gnt_wait--;
      end
      @(posedge clk);
      cycle++;
      #1;
      qsize       = rsp_time_q.size();
      rv_next     = (qsize > 0) && (rsp_time_q[0] <= cycle);
      data_rvalid = rv_next;
      if (rv_next) begin
        data_rdata = rsp_data_q.pop_front();
        void'(rsp_time_q.pop_front());
      end else begin
        data_rdata = 32'h0bad_0bad;
      end
      // grant also while a response is still pending
      data_gnt = !hold_gnt && (gnt_wait == 0);
    end
  end

  initial begin : rvalid_monitor
    word_t exp;
    bit    chk;
    forever begin
      @(negedge clk);
      if (rst_n && data_rvalid) begin
        if (exp_check_q.size() == 0) begin
          $display("rvalid arrived with no access pending");
          stop_on_failure();
        end else begin
          exp = exp_rdata_q.pop_front();
          chk = exp_check_q.pop_front();
          check_flag("busy_o", busy, 1'b1);
          check_flag("lsu_ready_wb_o", ready_wb, 1'b1);
          if (chk) check_word("ex_rdata_o", ex_rdata, exp);
        end
      end
    end
  end

  initial begin : watchdog
    wait (loaded);
    repeat ((num_lines + 1) * 40) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", (num_lines + 1) * 40);
    stop_on_failure();
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main_seq
    int i;
    seed          = 83;
    cycle         = 0;
    failed        = 1'b0;
    loaded        = 1'b0;
    depth_reached = 1'b0;
    num_lines     = 0;
    rst_n         = 1'b0;
    ex_valid      = 1'b0;
    ex_req        = '0;
    hold_gnt      = 1'b1;  // first access sees back-pressure
    read_testdata();
    loaded = 1'b1;
    repeat (16) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);
    check_flag("data_req_o", data_req, 1'b0);
    check_flag("busy_o", busy, 1'b0);
    check_flag("lsu_ready_ex_o", ready_ex, 1'b1);
    check_flag("lsu_ready_wb_o", ready_wb, 1'b1);
    @(posedge clk);
    #1;
    for (i = 0; i < num_lines; i++) begin
      run_access(i, (i == 0) ? 5 : 0);  // back to back, no idle cycle
    end
    ex_valid = 1'b0;
    while (exp_check_q.size() != 0) @(posedge clk);
    @(negedge clk);
    check_flag("busy_o", busy, 1'b0);  // drops after the last rvalid
    check_flag("data_req_o", data_req, 1'b0);
    if (!depth_reached) begin
      $display("two transactions were never outstanding at the same time");
      stop_on_failure();
    end
    if (!failed && num_lines > 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("Test failures found");
      $fatal(1);
    end
  end

endmodule

// File: verification/lsu_testdata.txt
# we size ext reg_off use_incr op_a op_b wdata mem0 mem1 misaligned
# addr0 be0 wdata0 addr1 be1 wdata1 rdata (all hex, second phase used when misaligned)
1 0 0 0 0 00001000 00000000 11223344 00000000 00000000 0 00001000 f 11223344 00000000 0 00000000 00000000
1 0 0 0 1 00001000 00000010 deadbeef 00000000 00000000 0 00001010 f deadbeef 00000000 0 00000000 00000000
1 1 0 0 0 00002000 00000000 0000abcd 00000000 00000000 0 00002000 3 0000abcd 00000000 0 00000000 00000000
1 1 0 0 0 00002002 00000000 0000abcd 00000000 00000000 0 00002002 c abcd0000 00000000 0 00000000 00000000
1 1 0 0 0 00002001 00000000 0000abcd 00000000 00000000 0 00002001 6 00abcd00 00000000 0 00000000 00000000
1 2 0 0 0 00003000 00000000 000000a5 00000000 00000000 0 00003000 1 000000a5 00000000 0 00000000 00000000
1 2 0 0 0 00003003 00000000 000000a5 00000000 00000000 0 00003003 8 a5000000 00000000 0 00000000 00000000
1 3 0 0 1 00003000 00000001 0000005a 00000000 00000000 0 00003001 2 00005a00 00000000 0 00000000 00000000
1 2 0 2 0 00003002 00000000 00770000 00000000 00000000 0 00003002 4 00770000 00000000 0 00000000 00000000
1 1 0 2 0 00004000 00000000 12340000 00000000 00000000 0 00004000 3 00001234 00000000 0 00000000 00000000
1 0 0 1 0 00004000 00000000 44332211 00000000 00000000 0 00004000 f 11443322 00000000 0 00000000 00000000
1 0 0 0 0 00005001 00000000 11223344 00000000 00000000 1 00005001 e 22334411 00005004 1 22334411 00000000
1 0 0 0 0 00005002 00000000 aabbccdd 00000000 00000000 1 00005002 c ccddaabb 00005004 3 ccddaabb 00000000
1 0 0 0 0 00005003 00000000 01020304 00000000 00000000 1 00005003 8 04010203 00005004 7 04010203 00000000
1 1 0 0 0 00006003 00000000 0000beef 00000000 00000000 1 00006003 8 ef0000be 00006004 1 ef0000be 00000000
1 0 0 0 1 00005000 00000001 11223344 00000000 00000000 1 00005001 e 22334411 00005004 1 22334411 00000000
0 0 0 0 0 00007000 00000000 00000000 89abcdef 00000000 0 00007000 f 00000000 00000000 0 00000000 89abcdef
0 1 0 0 0 00007000 00000000 00000000 1234f678 00000000 0 00007000 3 00000000 00000000 0 00000000 0000f678
0 1 1 0 0 00007000 00000000 00000000 1234f678 00000000 0 00007000 3 00000000 00000000 0 00000000 fffff678
0 1 2 0 0 00007002 00000000 00000000 12347678 00000000 0 00007002 c 00000000 00000000 0 00000000 ffff1234
0 1 3 0 0 00007002 00000000 00000000 8765aaaa 00000000 0 00007002 c 00000000 00000000 0 00000000 ffff8765
0 1 1 0 0 00007002 00000000 00000000 12347678 00000000 0 00007002 c 00000000 00000000 0 00000000 00001234
0 1 0 0 0 00007001 00000000 00000000 00beef00 00000000 0 00007001 6 00000000 00000000 0 00000000 0000beef
0 2 1 0 0 00007100 00000000 00000000 00000080 00000000 0 00007100 1 00000000 00000000 0 00000000 ffffff80
0 2 0 0 0 00007101 00000000 00000000 0000f000 00000000 0 00007101 2 00000000 00000000 0 00000000 000000f0
0 2 2 0 0 00007103 00000000 00000000 7f000000 00000000 0 00007103 8 00000000 00000000 0 00000000 ffffff7f
0 3 1 0 0 00007102 00000000 00000000 00450000 00000000 0 00007102 4 00000000 00000000 0 00000000 00000045
0 2 2 0 1 00007100 00000002 00000000 00450000 00000000 0 00007102 4 00000000 00000000 0 00000000 ffffff45
0 0 0 0 0 00008001 00000000 00000000 44332211 88776655 1 00008001 e 00000000 00008004 1 00000000 55443322
0 0 0 0 0 00008002 00000000 00000000 44332211 88776655 1 00008002 c 00000000 00008004 3 00000000 66554433
0 0 0 0 0 00008003 00000000 00000000 44332211 88776655 1 00008003 8 00000000 00008004 7 00000000 77665544
0 1 1 0 0 00009003 00000000 00000000 aa000000 000000bb 1 00009003 8 00000000 00009004 1 00000000 ffffbbaa
0 1 0 0 0 00009003 00000000 00000000 34000000 00000012 1 00009003 8 00000000 00009004 1 00000000 00001234
0 1 2 0 1 00009000 00000003 00000000 cd000000 000000ab 1 00009003 8 00000000 00009004 1 00000000 ffffabcd

// File: flist.f
rtl/lsu_pkg.sv
rtl/lsu_request.sv
rtl/lsu_txn_ctrl.sv
rtl/lsu_rdata_align.sv
rtl/lsu_top.sv
verification/lsu_checker.sv
verification/lsu_tb.sv

// File: Makefile
# Verilator build and run for the load/store unit testbench

VERILATOR ?= verilator
TOP       ?= lsu_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "All tests passed!" $(LOG) || (echo "simulation FAILED" && exit 1)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
